// ==== nano_link_buffer.f ====
+incdir+test
source/link_buffer_pkg.sv
source/sdpram_bypass.sv
source/buffer_ctrl.sv
source/credit_sender.sv
source/link_buffer.sv
test/link_buffer_tb.sv

// ==== Bender.yml ====
package:
  name: nano_link_buffer

sources:
  # Package first, then the blocks, top level last
  - files:
      - source/link_buffer_pkg.sv
      - source/sdpram_bypass.sv
      - source/buffer_ctrl.sv
      - source/credit_sender.sv
      - source/link_buffer.sv

  # Testbench and its included case table
  - target: test
    include_dirs:
      - test
    files:
      - test/link_buffer_tb.sv

// ==== test/link_buffer_cases.svh ====
/*
 * Link buffer test cases
 * One row per case, applied in order by the testbench
 */

`ifndef LINK_BUFFER_CASES_SVH
`define LINK_BUFFER_CASES_SVH

// Columns: name, items, producer gap (-1 random 0..3), credit return delay,
// consumer hold cycles at case start, fixed latency (0 unchecked), full rate
typedef struct packed {
   logic [127:0] name;
   int           n_items;
   int           gap;
   int           credit_delay;
   int           hold;
   int           exp_latency;
   bit           full_rate;
} case_t;

localparam int NUM_CASES = 6;

localparam case_t CASES [NUM_CASES] = '{
   // Initial downstream credits only, two items stay buffered
   '{"reset_credits", 6, 0, 0, 30, 0, 1'b0},
   // Every item meets an empty buffer
   '{"fall_through", 8, 4, 0, 0, 1, 1'b0},
   // Producer runs out of credits while the consumer holds back
   '{"fill_and_hold", 16, 0, 1, 40, 0, 1'b0},
   // Back to back traffic
   '{"streaming", 24, 0, 0, 0, 1, 1'b1},
   '{"slow_consumer", 20, 0, 6, 0, 0, 1'b0},
   '{"random_gaps", 30, -1, 2, 0, 0, 1'b0}
};

`endif

// ==== test/link_buffer_tb.sv ====
/*
 * Link buffer testbench
 * Table-driven producer and consumer models with a queue scoreboard
 */

`timescale 1ns/1ps

module link_buffer_tb
   import link_buffer_pkg::*;
();

   localparam int ADDR_W        = 3;
   localparam int OUT_CREDITS   = 4;
   localparam int ENABLE_BYPASS = 1;
   localparam int DEPTH         = 2 ** ADDR_W;
   localparam int RESET_CYCLES  = 4;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   `include "link_buffer_cases.svh"

   logic       clk;
   logic       reset;
   logic       in_valid;
   link_item_t in_item;
   logic       in_credit;
   logic       out_valid;
   link_item_t out_item;
   logic       out_credit;

   // Stimulus source
   logic [31:0] lfsr_state = 32'd90413;

   // Scoreboard of items and the cycle each entered
   link_item_t exp_q [$];
   int         exp_cyc_q [$];

   // Due cycle of each consumer credit return
   int due_q [$];

   // Parameters of the running case
   logic [127:0] cur_name;
   int           credit_delay;
   int           cur_lat;
   logic         withhold;

   // Counters
   int cycle;
   int out_total;
   int out_case;
   int sent_case;
   int ret_total;
   int first_out;
   int last_out;

   link_buffer #(
      .ADDR_W        (ADDR_W),
      .OUT_CREDITS   (OUT_CREDITS),
      .ENABLE_BYPASS (ENABLE_BYPASS)
   ) link_buffer_inst (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_item    (in_item),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_item   (out_item),
      .out_credit (out_credit)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1, "stopped at first error");
   endtask

   // Galois step giving one output bit per call
   function automatic logic lfsr_step();
      logic out_bit;
      out_bit = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
         lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      return out_bit;
   endfunction

   function automatic data_t take_bits(input int n);
      data_t v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[DATA_W-2:0], lfsr_step()};
      end
      return v;
   endfunction

   // Generous bound from item counts, gaps, delays and holds
   function automatic int budget_cycles();
      int total;
      int g;
      total = 100;
      for (int i = 0; i < NUM_CASES; i++) begin
         g = (CASES[i].gap < 0) ? 3 : CASES[i].gap;
         total += CASES[i].n_items * (g + 2 + CASES[i].credit_delay);
         total += CASES[i].hold + 40;
      end
      return total;
   endfunction

   initial begin
      repeat (budget_cycles()) @(posedge clk);
      abort_run("timeout: the link stopped delivering items");
   end

   task automatic check_idle();
      assert (out_valid === 1'b0 && in_credit === 1'b0)
         else abort_run("out_valid or in_credit not low around reset");
   endtask

   // Output side against the oldest item sent
   task automatic check_output();
      link_item_t exp;
      int         lat;
      out_total++;
      out_case++;
      if (out_case == 1) begin
         first_out = cycle;
      end
      last_out = cycle;
      assert (out_total <= OUT_CREDITS + ret_total)
         else abort_run("more items sent downstream than credits allow");
      assert (exp_q.size() > 0)
         else abort_run("out_valid with no item outstanding");
      exp = exp_q.pop_front();
      lat = cycle - exp_cyc_q.pop_front();
      assert (out_item === exp)
         else abort_run($sformatf("mismatch %0s item: expected %h actual %h",
                                  cur_name, exp, out_item));
      if (cur_lat > 0) begin
         assert (lat == cur_lat)
            else abort_run($sformatf("mismatch %0s latency: expected %0d actual %0d",
                                     cur_name, cur_lat, lat));
      end
   endtask

   // Monitor and consumer model
   always @(posedge clk) begin
      if (!reset) begin
         cycle++;
         // Both follow a read issue by one cycle
         assert (in_credit === out_valid)
            else abort_run("in_credit pulse does not line up with out_valid");
         if (out_valid) begin
            check_output();
            due_q.push_back(cycle + credit_delay);
         end
         if (in_valid) begin
            exp_q.push_back(in_item);
            exp_cyc_q.push_back(cycle);
         end
         // At most one credit back per cycle
         if (!withhold && due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            out_credit <= 1'b1;
            ret_total++;
         end else begin
            out_credit <= 1'b0;
         end
      end
   end

   // Producer spending one credit per item
   task automatic drive_items(input case_t c);
      int         credits;
      int         idle;
      link_item_t item;
      credits = DEPTH;
      idle = 0;
      while (sent_case < c.n_items) begin
         @(posedge clk);
         if (in_credit) begin
            credits++;
         end
         if (idle > 0 || credits == 0) begin
            idle = (idle > 0) ? idle - 1 : 0;
            in_valid <= 1'b0;
         end else begin
            item.payload = take_bits(DATA_W);
            item.tag = tag_t'(take_bits(4));
            item.last = (sent_case == c.n_items - 1);
            in_valid <= 1'b1;
            in_item <= item;
            credits--;
            sent_case++;
            idle = (c.gap < 0) ? int'(take_bits(2)) : c.gap;
         end
      end
      @(posedge clk);
      in_valid <= 1'b0;
   endtask

   // Consumer hold followed by a check of what got through
   task automatic release_credits(input case_t c);
      int exp_out;
      int exp_sent;
      if (c.hold > 0) begin
         repeat (c.hold) @(negedge clk);
         exp_out = (c.n_items < OUT_CREDITS) ? c.n_items : OUT_CREDITS;
         exp_sent = (c.n_items < DEPTH + OUT_CREDITS) ? c.n_items : DEPTH + OUT_CREDITS;
         assert (out_case == exp_out)
            else abort_run($sformatf("mismatch %0s held out count: expected %0d actual %0d",
                                     cur_name, exp_out, out_case));
         assert (sent_case == exp_sent)
            else abort_run($sformatf("mismatch %0s held sent count: expected %0d actual %0d",
                                     cur_name, exp_sent, sent_case));
         withhold = 1'b0;
      end
   endtask

   task automatic run_case(input case_t c);
      cur_name = c.name;
      credit_delay = c.credit_delay;
      cur_lat = c.exp_latency;
      withhold = (c.hold > 0);
      out_case = 0;
      sent_case = 0;
      fork
         drive_items(c);
         release_credits(c);
      join
      // Drained once all items left and every credit came back
      @(negedge clk);
      while (!(out_case == c.n_items && ret_total == out_total &&
               !in_credit && !out_valid && !out_credit)) begin
         @(negedge clk);
      end
      if (c.full_rate) begin
         assert (last_out - first_out + 1 == c.n_items)
            else abort_run($sformatf("mismatch %0s output span: expected %0d actual %0d",
                                     cur_name, c.n_items, last_out - first_out + 1));
      end
   endtask

   initial begin
      reset = 1'b1;
      in_valid = 1'b0;
      in_item = '0;
      out_credit = 1'b0;
      withhold = 1'b0;
      credit_delay = 0;
      cur_lat = 0;
      repeat (RESET_CYCLES - 1) begin
         @(negedge clk);
         check_idle();
      end
      @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_idle();
      @(negedge clk);
      check_idle();

      for (int i = 0; i < NUM_CASES; i++) begin
         run_case(CASES[i]);
      end

      if (exp_q.size() == 0) begin
         $display("Verification passed");
         $finish;
      end else begin
         abort_run("items left in the scoreboard after the last case");
      end
   end

endmodule

// ==== source/link_buffer.sv ====
/*
 * Credit-based elastic link buffer
 * Controller, item RAM and downstream credit sender
 */

`timescale 1ns/1ps

module link_buffer
   import link_buffer_pkg::*;
#(
   parameter int ADDR_W        = 3,
   parameter int OUT_CREDITS   = 4,
   parameter int ENABLE_BYPASS = 1
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       in_valid,
   input  link_item_t in_item,
   output logic       in_credit,
   output logic       out_valid,
   output link_item_t out_item,
   input  logic       out_credit
);

   // RAM control
   logic [ADDR_W-1:0] waddr;
   logic [ADDR_W-1:0] raddr;
   logic              we;
   logic              re;
   link_item_t        rdata;

   // Controller to sender handshake
   logic              can_send;
   logic              read_issue;

   buffer_ctrl #(
      .ADDR_W        (ADDR_W),
      .ENABLE_BYPASS (ENABLE_BYPASS)
   ) buffer_ctrl_inst (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .can_send   (can_send),
      .waddr      (waddr),
      .raddr      (raddr),
      .we         (we),
      .re         (re),
      .read_issue (read_issue),
      .in_credit  (in_credit)
   );

   // Incoming item written directly
   sdpram_bypass #(
      .ADDR_W        (ADDR_W),
      .ENABLE_BYPASS (ENABLE_BYPASS)
   ) sdpram_bypass_inst (
      .clk   (clk),
      .reset (reset),
      .raddr (raddr),
      .waddr (waddr),
      .re    (re),
      .we    (we),
      .wdata (in_item),
      .rdata (rdata)
   );

   credit_sender #(
      .OUT_CREDITS (OUT_CREDITS)
   ) credit_sender_inst (
      .clk        (clk),
      .reset      (reset),
      .read_issue (read_issue),
      .out_credit (out_credit),
      .rdata      (rdata),
      .can_send   (can_send),
      .out_valid  (out_valid),
      .out_item   (out_item)
   );

endmodule

// ==== source/credit_sender.sv ====
/*
 * Downstream credit sender
 * Tracks consumer credits and drives the output valid and item
 */

`timescale 1ns/1ps

module credit_sender
   import link_buffer_pkg::*;
#(
   parameter int OUT_CREDITS = 4
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       read_issue,
   input  logic       out_credit,
   input  link_item_t rdata,
   output logic       can_send,
   output logic       out_valid,
   output link_item_t out_item
);

   localparam credit_cnt_t INIT_CREDITS = credit_cnt_t'(OUT_CREDITS);

   credit_cnt_t credit_cnt;
   credit_cnt_t credit_next;
   logic        have_credit;

   assign have_credit = (credit_cnt != '0);

   // A credit returning now is usable in the same cycle
   assign can_send = have_credit || out_credit;

   // Return and spend in one cycle leave the count alone
   always_comb begin
      case ({out_credit, read_issue})
         2'b10:   credit_next = credit_cnt + credit_cnt_t'(1);
         2'b01:   credit_next = credit_cnt - credit_cnt_t'(1);
         default: credit_next = credit_cnt;
      endcase
   end

   // Credit counter
   always_ff @(posedge clk) begin
      if (reset) begin
         credit_cnt <= INIT_CREDITS;
      end else begin
         credit_cnt <= credit_next;
      end
   end

   // Output valid follows the read by one cycle, like the RAM data
   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= read_issue;
      end
   end

   // RAM word lines up with out_valid
   assign out_item = rdata;

endmodule

// ==== source/buffer_ctrl.sv ====
/*
 * Buffer controller
 * Write and read pointers, occupancy, read issue and upstream credits
 */

`timescale 1ns/1ps

module buffer_ctrl #(
   parameter int ADDR_W        = 3,
   parameter int ENABLE_BYPASS = 1
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              in_valid,
   input  logic              can_send,
   output logic [ADDR_W-1:0] waddr,
   output logic [ADDR_W-1:0] raddr,
   output logic              we,
   output logic              re,
   output logic              read_issue,
   output logic              in_credit
);

   // Pointer into the RAM, wraps naturally at the depth
   typedef logic [ADDR_W-1:0] ptr_t;

   // Occupancy, one bit wider so a full buffer is representable
   typedef logic [ADDR_W:0] occ_t;

   localparam bit BYPASS_ON = (ENABLE_BYPASS != 0);

   ptr_t wr_ptr;
   ptr_t rd_ptr;
   occ_t occupancy;

   ptr_t wr_ptr_next;
   ptr_t rd_ptr_next;
   occ_t occ_next;

   logic buf_empty;
   logic has_stored;
   logic fall_through;
   logic issue;

   // Occupancy state
   assign buf_empty  = (occupancy == '0);
   assign has_stored = !buf_empty;

   // Item written this cycle into an empty buffer may leave at once
   // through the RAM bypass; without bypass it waits a cycle
   assign fall_through = BYPASS_ON && in_valid && buf_empty;

   // Read decision, only when downstream can take the item
   always_comb begin
      issue = 1'b0;
      if (can_send) begin
         if (has_stored) begin
            issue = 1'b1;
         end else if (fall_through) begin
            issue = 1'b1;
         end
      end
   end

   // RAM control straight from the pointers
   assign we         = in_valid;
   assign waddr      = wr_ptr;
   assign re         = issue;
   assign raddr      = rd_ptr;
   assign read_issue = issue;

   // Next pointer values
   always_comb begin
      wr_ptr_next = wr_ptr;
      rd_ptr_next = rd_ptr;
      if (in_valid) begin
         wr_ptr_next = wr_ptr + ptr_t'(1);
      end
      if (issue) begin
         rd_ptr_next = rd_ptr + ptr_t'(1);
      end
   end

   // Next occupancy, fall-through write and read cancel out
   always_comb begin
      occ_next = occupancy;
      case ({in_valid, issue})
         2'b10:   occ_next = occupancy + occ_t'(1);
         2'b01:   occ_next = occupancy - occ_t'(1);
         default: occ_next = occupancy;
      endcase
   end

   // Pointer registers
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         wr_ptr <= wr_ptr_next;
         rd_ptr <= rd_ptr_next;
      end
   end

   // Occupancy register
   always_ff @(posedge clk) begin
      if (reset) begin
         occupancy <= '0;
      end else begin
         occupancy <= occ_next;
      end
   end

   // One upstream credit back per freed entry, a cycle after the read
   always_ff @(posedge clk) begin
      if (reset) begin
         in_credit <= 1'b0;
      end else begin
         in_credit <= issue;
      end
   end

endmodule

// ==== source/sdpram_bypass.sv ====
/*
 * Simple dual-port synchronous RAM holding link items
 * Registered read port with optional read-during-write bypass
 */

`timescale 1ns/1ps

module sdpram_bypass
   import link_buffer_pkg::*;
#(
   parameter int ADDR_W        = 3,
   parameter int ENABLE_BYPASS = 1
) (
   input  logic              clk,
   input  logic              reset,
   input  logic [ADDR_W-1:0] raddr,
   input  logic [ADDR_W-1:0] waddr,
   input  logic              re,
   input  logic              we,
   input  link_item_t        wdata,
   output link_item_t        rdata
);

   localparam int DEPTH = 2 ** ADDR_W;

   // Storage array, no reset
   logic [ITEM_W-1:0] mem [DEPTH];

   // Registered read word
   logic [ITEM_W-1:0] ram_q;

   // Read enable actually seen by the array
   logic              ram_re;

   // Write port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Read port, data valid one cycle after the enable
   always_ff @(posedge clk) begin
      if (ram_re) begin
         ram_q <= mem[raddr];
      end
   end

   generate
      if (ENABLE_BYPASS != 0) begin : g_bypass
         logic       collide;
         logic       bypass_q;
         link_item_t wdata_q;

         // Same address written and read in one cycle
         assign collide = we && re && (waddr == raddr);

         // Bypass select, held until the next read
         always_ff @(posedge clk) begin
            if (reset) begin
               bypass_q <= 1'b0;
            end else if (re) begin
               bypass_q <= collide;
            end
         end

         // Copy of the incoming word for the collision case
         always_ff @(posedge clk) begin
            if (collide) begin
               wdata_q <= wdata;
            end
         end

         // Array read would return the stale word, skip it
         assign ram_re = re && !collide;
         assign rdata  = bypass_q ? wdata_q : link_item_t'(ram_q);
      end else begin : g_no_bypass
         // Plain registered read
         assign ram_re = re;
         assign rdata  = link_item_t'(ram_q);
      end
   endgenerate

endmodule

// ==== source/link_buffer_pkg.sv ====
/*
 * Link buffer package
 * Payload width, link item layout and the credit counter type
 */

package link_buffer_pkg;

   // Payload width of one link item
   localparam int DATA_W = 32;

   // Width of the credit counters, enough for any sane link depth
   localparam int CREDIT_W = 8;

   // Payload word
   typedef logic [DATA_W-1:0] data_t;

   // Transaction tag
   typedef logic [3:0] tag_t;

   // Credit count on a link
   typedef logic [CREDIT_W-1:0] credit_cnt_t;

   // One item as carried on the link and stored in the RAM
   typedef struct packed {
      data_t payload;
      tag_t  tag;
      logic  last;     // End of packet
   } link_item_t;

   // Stored word width, 37 bits with the defaults above
   localparam int ITEM_W = $bits(link_item_t);

endpackage
